// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= conv_tb
RTL_TOP    ?= conv_top
FILELIST   ?= conv_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/conv_consts.svh ====
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// image and kernel geometry
`define CONV_IMG_W        4
`define CONV_KERN_SZ      3
`define CONV_TAPS         9
`define CONV_OUT_W        2

// datapath widths
`define CONV_PIX_W        8
`define CONV_ACC_W        20
`define CONV_OUT_DW       32

// lane latency 3 plus accumulator latency 2
`define CONV_DRAIN_CYCLES 5

// apb map, byte addresses
`define CONV_APB_AW       12
`define CONV_APB_DW       32
`define CONV_WORD_STRIDE  4
`define CONV_ADDR_CTRL    12'h000
`define CONV_ADDR_STATUS  12'h004
`define CONV_BASE_IMG0    12'h100
`define CONV_BASE_KERN0   12'h140
`define CONV_BASE_IMG1    12'h200
`define CONV_BASE_KERN1   12'h240
`define CONV_BASE_OUT     12'h300

`endif

// ==== common/conv_ifs.sv ====
// one tap per cycle while tap_valid, no back-pressure
interface tap_if;
  logic                   tap_valid;
  conv_pkg::pix_addr_t    pix_addr;
  conv_pkg::kern_addr_t   kern_addr;
  conv_pkg::pos_t         pos;

  modport seq (
    output tap_valid,
    output pix_addr,
    output kern_addr,
    output pos
  );

  modport lane (
    input tap_valid,
    input pix_addr,
    input kern_addr,
    input pos
  );
endinterface

// host writes into lane image and kernel memories
interface host_wr_if;
  logic                   wr_en;
  logic                   wr_lane;
  logic                   wr_kernel;
  conv_pkg::pix_addr_t    wr_addr;
  conv_pkg::pix_t         wr_data;

  modport host (
    output wr_en,
    output wr_lane,
    output wr_kernel,
    output wr_addr,
    output wr_data
  );

  modport lane (
    input wr_en,
    input wr_lane,
    input wr_kernel,
    input wr_addr,
    input wr_data
  );
endinterface

// ==== common/conv_pkg.sv ====
`include "conv_consts.svh"

package conv_pkg;

  typedef logic [`CONV_PIX_W-1:0] pix_t;
  typedef logic [3:0] pix_addr_t;
  typedef logic [3:0] kern_addr_t;
  typedef logic [1:0] pos_t;
  typedef logic [`CONV_ACC_W-1:0] lane_sum_t;
  typedef logic [`CONV_OUT_DW-1:0] out_word_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DRAIN
  } seq_state_e;

  // decoded apb region
  typedef enum logic [2:0] {
    REG_CTRL,
    REG_STATUS,
    REG_IMG,
    REG_KERN,
    REG_OUT,
    REG_NONE
  } region_e;

endpackage

// ==== conv_lane/conv_lane.sv ====
`include "conv_consts.svh"

module conv_lane #(
  parameter int LANE_ID = 0
) (
  input  logic                 clk,
  input  logic                 rst,
  host_wr_if.lane              host_wr,
  tap_if.lane                  tap,
  output logic                 result_valid,
  output conv_pkg::lane_sum_t  result,
  output conv_pkg::pos_t       result_pos
);
  import conv_pkg::*;

  pix_t                     img_mem [`CONV_IMG_W * `CONV_IMG_W];
  pix_t                     kern_mem [`CONV_TAPS];
  logic                     lane_hit;

  logic                     v1;
  logic                     v2;
  logic                     first1;
  logic                     first2;
  logic                     last1;
  logic                     last2;
  pos_t                     pos1;
  pos_t                     pos2;
  pix_t                     pix_r;
  pix_t                     wt_r;
  logic [2*`CONV_PIX_W-1:0] prod_r;

  assign lane_hit = host_wr.wr_en && (host_wr.wr_lane == 1'(LANE_ID));

  always_ff @(posedge clk) begin
    if (lane_hit) begin
      if (host_wr.wr_kernel) begin
        if (host_wr.wr_addr < kern_addr_t'(`CONV_TAPS)) begin
          kern_mem[host_wr.wr_addr] <= host_wr.wr_data;
        end
      end else begin
        img_mem[host_wr.wr_addr] <= host_wr.wr_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v1           <= 1'b0;
      v2           <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      v1           <= tap.tap_valid;
      v2           <= v1;
      result_valid <= v2 && last2;
    end
  end

  // stage 1 fetch, stage 2 multiply
  always_ff @(posedge clk) begin
    pix_r  <= img_mem[tap.pix_addr];
    wt_r   <= kern_mem[tap.kern_addr];
    first1 <= (tap.kern_addr == '0);
    last1  <= (tap.kern_addr == kern_addr_t'(`CONV_TAPS - 1));
    pos1   <= tap.pos;
    prod_r <= pix_r * wt_r;
    first2 <= first1;
    last2  <= last1;
    pos2   <= pos1;
  end

  // stage 3, tap 0 restarts the window sum
  always_ff @(posedge clk) begin
    if (v2) begin
      if (first2) begin
        result <= lane_sum_t'(prod_r);
      end else begin
        result <= result + lane_sum_t'(prod_r);
      end
      result_pos <= pos2;
    end
  end

endmodule

// ==== conv_top.f ====
+incdir+common
+incdir+tb
common/conv_pkg.sv
common/conv_ifs.sv
src/apb_regs.sv
src/window_sequencer.sv
conv_lane/conv_lane.sv
src/psum_accum.sv
src/conv_top.sv
tb/conv_tb.sv

// ==== src/apb_regs.sv ====
`include "conv_consts.svh"

module apb_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`CONV_APB_AW-1:0]  paddr,
  input  logic [`CONV_APB_DW-1:0]  pwdata,
  input  logic                     busy,
  input  conv_pkg::out_word_t      rd_data,
  output logic [`CONV_APB_DW-1:0]  prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     start,
  output logic                     clear,
  output conv_pkg::pos_t           rd_pos,
  host_wr_if.host                  host_wr
);
  import conv_pkg::*;

  localparam int IMG_SPAN  = `CONV_IMG_W * `CONV_IMG_W * `CONV_WORD_STRIDE;
  localparam int KERN_SPAN = `CONV_TAPS * `CONV_WORD_STRIDE;
  localparam int OUT_SPAN  = `CONV_OUT_W * `CONV_OUT_W * `CONV_WORD_STRIDE;

  region_e                 region;
  logic                    lane_sel;
  logic [`CONV_APB_AW-1:0] off;
  logic                    access;
  logic                    err;
  logic                    wr_ok;
  logic                    mem_region;

  function automatic logic in_win(input logic [`CONV_APB_AW-1:0] addr,
                                  input logic [`CONV_APB_AW-1:0] base,
                                  input int span);
    return (addr >= base) && (int'(addr) < int'(base) + span);
  endfunction

  // address decode, misaligned counts as unmapped
  always_comb begin
    region   = REG_NONE;
    lane_sel = 1'b0;
    off      = '0;
    if (paddr[1:0] != 2'b00) begin
      region = REG_NONE;
    end else if (paddr == `CONV_ADDR_CTRL) begin
      region = REG_CTRL;
    end else if (paddr == `CONV_ADDR_STATUS) begin
      region = REG_STATUS;
    end else if (in_win(paddr, `CONV_BASE_IMG0, IMG_SPAN)) begin
      region = REG_IMG;
      off    = paddr - `CONV_BASE_IMG0;
    end else if (in_win(paddr, `CONV_BASE_KERN0, KERN_SPAN)) begin
      region = REG_KERN;
      off    = paddr - `CONV_BASE_KERN0;
    end else if (in_win(paddr, `CONV_BASE_IMG1, IMG_SPAN)) begin
      region   = REG_IMG;
      lane_sel = 1'b1;
      off      = paddr - `CONV_BASE_IMG1;
    end else if (in_win(paddr, `CONV_BASE_KERN1, KERN_SPAN)) begin
      region   = REG_KERN;
      lane_sel = 1'b1;
      off      = paddr - `CONV_BASE_KERN1;
    end else if (in_win(paddr, `CONV_BASE_OUT, OUT_SPAN)) begin
      region = REG_OUT;
      off    = paddr - `CONV_BASE_OUT;
    end
  end

  assign access     = psel && penable;
  assign mem_region = (region == REG_IMG) || (region == REG_KERN);

  assign err = (region == REG_NONE) ||
               (pwrite && busy && (mem_region || region == REG_CTRL)) ||
               (pwrite && region == REG_CTRL && pwdata[1:0] == 2'b11);

  assign pready  = access;
  assign pslverr = access && err;
  assign wr_ok   = access && pwrite && !err;

  // start goes straight to the sequencer so busy rises next cycle
  assign start  = wr_ok && region == REG_CTRL && pwdata[0];
  assign rd_pos = pos_t'(off >> 2);

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (region)
        REG_STATUS: prdata = {{(`CONV_APB_DW-1){1'b0}}, busy};
        REG_OUT:    prdata = rd_data;
        default:    prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      host_wr.wr_en <= 1'b0;
      clear         <= 1'b0;
    end else begin
      host_wr.wr_en <= wr_ok && mem_region;
      clear         <= wr_ok && region == REG_CTRL && pwdata[1];
    end
  end

  always_ff @(posedge clk) begin
    host_wr.wr_lane   <= lane_sel;
    host_wr.wr_kernel <= (region == REG_KERN);
    host_wr.wr_addr   <= pix_addr_t'(off >> 2);
    host_wr.wr_data   <= pwdata[`CONV_PIX_W-1:0];
  end

endmodule

// ==== src/conv_top.sv ====
`include "conv_consts.svh"

module conv_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`CONV_APB_AW-1:0] paddr,
  input  logic [`CONV_APB_DW-1:0] pwdata,
  output logic [`CONV_APB_DW-1:0] prdata,
  output logic                    pready,
  output logic                    pslverr
);
  import conv_pkg::*;

  logic      start;
  logic      busy;
  logic      clear;
  pos_t      rd_pos;
  out_word_t rd_data;
  logic      l0_valid;
  logic      l1_valid;
  lane_sum_t l0_result;
  lane_sum_t l1_result;
  pos_t      l0_pos;
  pos_t      l1_pos;

  tap_if     taps ();
  host_wr_if host_wr ();

  apb_regs u_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .busy    (busy),
    .rd_data (rd_data),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .start   (start),
    .clear   (clear),
    .rd_pos  (rd_pos),
    .host_wr (host_wr.host)
  );

  window_sequencer u_seq (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .tap   (taps.seq)
  );

  // one lane per depth channel
  conv_lane #(.LANE_ID(0)) lane_0 (
    .clk          (clk),
    .rst          (rst),
    .host_wr      (host_wr.lane),
    .tap          (taps.lane),
    .result_valid (l0_valid),
    .result       (l0_result),
    .result_pos   (l0_pos)
  );

  conv_lane #(.LANE_ID(1)) lane_1 (
    .clk          (clk),
    .rst          (rst),
    .host_wr      (host_wr.lane),
    .tap          (taps.lane),
    .result_valid (l1_valid),
    .result       (l1_result),
    .result_pos   (l1_pos)
  );

  psum_accum u_psum (
    .clk                (clk),
    .rst                (rst),
    .clear              (clear),
    .lane0_result_valid (l0_valid),
    .lane0_result       (l0_result),
    .lane0_result_pos   (l0_pos),
    .lane1_result_valid (l1_valid),
    .lane1_result       (l1_result),
    .lane1_result_pos   (l1_pos),
    .rd_pos             (rd_pos),
    .rd_data            (rd_data)
  );

endmodule

// ==== src/psum_accum.sv ====
`include "conv_consts.svh"

module psum_accum (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear,
  input  logic                 lane0_result_valid,
  input  conv_pkg::lane_sum_t  lane0_result,
  input  conv_pkg::pos_t       lane0_result_pos,
  input  logic                 lane1_result_valid,
  input  conv_pkg::lane_sum_t  lane1_result,
  input  conv_pkg::pos_t       lane1_result_pos,
  input  conv_pkg::pos_t       rd_pos,
  output conv_pkg::out_word_t  rd_data
);
  import conv_pkg::*;

  localparam int N_POS = `CONV_OUT_W * `CONV_OUT_W;

  out_word_t store [N_POS];
  out_word_t sum_r;
  pos_t      pos_r;
  logic      sum_valid;

  // both lanes run in lockstep on the same window
  always_ff @(posedge clk) begin
    if (rst) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= lane0_result_valid && lane1_result_valid &&
                   (lane0_result_pos == lane1_result_pos);
    end
  end

  always_ff @(posedge clk) begin
    sum_r <= out_word_t'(lane0_result) + out_word_t'(lane1_result);
    pos_r <= lane0_result_pos;
  end

  // read-modify-write into the entry, wraps at 32 bits
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      for (int i = 0; i < N_POS; i++) begin
        store[i] <= '0;
      end
    end else if (sum_valid) begin
      store[pos_r] <= store[pos_r] + sum_r;
    end
  end

  assign rd_data = store[rd_pos];

endmodule

// ==== src/window_sequencer.sv ====
`include "conv_consts.svh"

module window_sequencer (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic busy,
  tap_if.seq   tap
);
  import conv_pkg::*;

  localparam int DRAIN_W = $clog2(`CONV_DRAIN_CYCLES);

  seq_state_e         state;
  pos_t               pos_cnt;
  logic [1:0]         tap_row;
  logic [1:0]         tap_col;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               last_tap;
  logic               last_pos;

  assign last_tap = (tap_row == 2'(`CONV_KERN_SZ - 1)) && (tap_col == 2'(`CONV_KERN_SZ - 1));
  assign last_pos = (pos_cnt == pos_t'(`CONV_OUT_W * `CONV_OUT_W - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= SEQ_IDLE;
      pos_cnt   <= '0;
      tap_row   <= '0;
      tap_col   <= '0;
      drain_cnt <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          pos_cnt <= '0;
          tap_row <= '0;
          tap_col <= '0;
          if (start) begin
            state <= SEQ_RUN;
          end
        end
        SEQ_RUN: begin
          if (tap_col == 2'(`CONV_KERN_SZ - 1)) begin
            tap_col <= '0;
            if (tap_row == 2'(`CONV_KERN_SZ - 1)) begin
              tap_row <= '0;
              pos_cnt <= pos_cnt + 1'b1;
            end else begin
              tap_row <= tap_row + 1'b1;
            end
          end else begin
            tap_col <= tap_col + 1'b1;
          end
          if (last_tap && last_pos) begin
            state     <= SEQ_DRAIN;
            drain_cnt <= '0;
          end
        end
        SEQ_DRAIN: begin
          // let the lane and accumulator pipes empty
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == DRAIN_W'(`CONV_DRAIN_CYCLES - 1)) begin
            state <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  assign busy = (state != SEQ_IDLE);

  // position row sits in bit 1, column in bit 0
  assign tap.tap_valid = (state == SEQ_RUN);
  assign tap.pos       = pos_cnt;
  assign tap.kern_addr = kern_addr_t'(tap_row * `CONV_KERN_SZ + tap_col);
  assign tap.pix_addr  = pix_addr_t'((pos_cnt[1] + tap_row) * `CONV_IMG_W + pos_cnt[0] + tap_col);

endmodule

// ==== tb/conv_tb_apb.svh ====
// one apb transfer with a setup phase and an access phase
task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
  int waited;
  @(posedge clk);
  psel    <= 1'b1;
  penable <= 1'b0;
  pwrite  <= wr;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge clk);
  penable <= 1'b1;
  waited = 0;
  // sample mid-cycle away from the edge
  @(negedge clk);
  while (!pready && waited < APB_TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  if (!pready) begin
    $display("apb transfer at address %h got no pready within %0d cycles", addr, APB_TIMEOUT);
    timeouts++;
    end_run();
  end else begin
    // pready is due in the first access cycle
    check_value($sformatf("apb wait states at %h", addr), 32'd0, 32'(waited));
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  end
endtask

task automatic write_reg(input logic [11:0] addr, input logic [31:0] data, output logic err);
  logic [31:0] unused_rdata;
  apb_transfer(1'b1, addr, data, unused_rdata, err);
endtask

task automatic read_reg(input logic [11:0] addr, output logic [31:0] data, output logic err);
  apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

// poll status until busy drops
task automatic wait_idle(input string name);
  logic [31:0] status;
  logic        err;
  int          polls;
  polls  = 0;
  status = 32'h1;
  while (status[0] && polls < POLL_LIMIT) begin
    read_reg(`CONV_ADDR_STATUS, status, err);
    check_value({name, " status pslverr"}, 32'd0, 32'(err));
    polls++;
  end
  if (status[0]) begin
    $display("%s: busy still high after %0d status polls", name, POLL_LIMIT);
    timeouts++;
    end_run();
  end
endtask

// ==== tb/conv_tb.sv ====
`include "conv_consts.svh"

module conv_tb;

  localparam int APB_TIMEOUT = 16;
  localparam int POLL_LIMIT  = 200;
  localparam int N_CASES     = 6;
  localparam int N_PIX       = `CONV_IMG_W * `CONV_IMG_W;
  localparam int N_POS       = `CONV_OUT_W * `CONV_OUT_W;

  typedef enum {FILL_RANDOM, FILL_FIXED, FILL_ZERO_K1, FILL_KEEP} fill_e;

  typedef struct {
    string name;
    fill_e fill;
    bit    clear_first;
    bit    poke_busy;
    bit    exp_poke_err;
  } case_t;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  integer      seed;
  int          errors;
  int          timeouts;
  logic [7:0]  img   [2][N_PIX];
  logic [7:0]  kern  [2][`CONV_TAPS];
  logic [31:0] model [N_POS];
  case_t       cases [N_CASES];

  `include "conv_tb_apb.svh"

  conv_top uut (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_run();
    $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // 3x3 window, position row p/2 and column p%2
  function automatic logic [31:0] dot_product(input int lane, input int p);
    logic [31:0] acc;
    int          pix;
    acc = '0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        pix = ((p / 2) + r) * 4 + (p % 2) + c;
        acc = acc + 32'(img[lane][pix]) * 32'(kern[lane][r * 3 + c]);
      end
    end
    return acc;
  endfunction

  task automatic load_planes(input fill_e fill);
    logic        err;
    logic [11:0] img_base;
    logic [11:0] kern_base;
    for (int l = 0; l < 2; l++) begin
      img_base  = (l == 0) ? `CONV_BASE_IMG0 : `CONV_BASE_IMG1;
      kern_base = (l == 0) ? `CONV_BASE_KERN0 : `CONV_BASE_KERN1;
      for (int i = 0; i < N_PIX; i++) begin
        img[l][i] = (fill == FILL_FIXED) ? 8'hff : 8'($random(seed));
        write_reg(img_base + 12'(4 * i), {24'h0, img[l][i]}, err);
        check_value("image load pslverr", 32'd0, 32'(err));
      end
      for (int k = 0; k < `CONV_TAPS; k++) begin
        if (fill == FILL_FIXED) begin
          kern[l][k] = 8'hff;
        end else if (fill == FILL_ZERO_K1 && l == 1) begin
          kern[l][k] = 8'h00;
        end else begin
          kern[l][k] = 8'($random(seed));
        end
        write_reg(kern_base + 12'(4 * k), {24'h0, kern[l][k]}, err);
        check_value("kernel load pslverr", 32'd0, 32'(err));
      end
    end
  endtask

  task automatic run_case(input case_t tc);
    logic [31:0] rdata;
    logic        err;
    string       tag;
    if (tc.clear_first) begin
      write_reg(`CONV_ADDR_CTRL, 32'h2, err);
      check_value({tc.name, " clear pslverr"}, 32'd0, 32'(err));
      for (int p = 0; p < N_POS; p++) begin
        model[p] = '0;
      end
    end
    if (tc.fill != FILL_KEEP) begin
      load_planes(tc.fill);
    end
    write_reg(`CONV_ADDR_CTRL, 32'h1, err);
    check_value({tc.name, " start pslverr"}, 32'd0, 32'(err));
    if (tc.poke_busy) begin
      read_reg(`CONV_ADDR_STATUS, rdata, err);
      check_value({tc.name, " busy after start"}, 32'd1, 32'(rdata[0]));
      write_reg(`CONV_ADDR_CTRL, 32'h1, err);
      check_value({tc.name, " start while busy"}, 32'(tc.exp_poke_err), 32'(err));
      // rejected, so the model keeps the old pixel
      write_reg(`CONV_BASE_IMG0 + 12'd20, {24'h0, ~img[0][5]}, err);
      check_value({tc.name, " image write while busy"}, 32'(tc.exp_poke_err), 32'(err));
    end
    wait_idle(tc.name);
    for (int p = 0; p < N_POS; p++) begin
      model[p] = model[p] + dot_product(0, p) + dot_product(1, p);
      tag = $sformatf("%s entry %0d", tc.name, p);
      read_reg(`CONV_BASE_OUT + 12'(4 * p), rdata, err);
      check_value(tag, model[p], rdata);
      check_value({tag, " pslverr"}, 32'd0, 32'(err));
      if (tc.fill == FILL_FIXED) begin
        check_value({tag, " all 255"}, 32'd1170450, rdata);
      end
      if (tc.fill == FILL_ZERO_K1) begin
        check_value({tag, " lane 0 only"}, dot_product(0, p), rdata);
      end
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    seed     = 32'h7a97_6d86;
    errors   = 0;
    timeouts = 0;
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;

    cases[0] = '{"random_first", FILL_RANDOM, 1'b1, 1'b0, 1'b0};
    cases[1] = '{"rerun_no_clear", FILL_KEEP, 1'b0, 1'b0, 1'b0};
    cases[2] = '{"random_after_clear", FILL_RANDOM, 1'b1, 1'b0, 1'b0};
    cases[3] = '{"zero_kernel_lane1", FILL_ZERO_K1, 1'b1, 1'b0, 1'b0};
    cases[4] = '{"all_255", FILL_FIXED, 1'b1, 1'b0, 1'b0};
    cases[5] = '{"busy_reject", FILL_RANDOM, 1'b1, 1'b1, 1'b1};

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    read_reg(`CONV_ADDR_STATUS, rdata, err);
    check_value("reset status", 32'd0, rdata);
    check_value("reset status pslverr", 32'd0, 32'(err));
    for (int p = 0; p < N_POS; p++) begin
      read_reg(`CONV_BASE_OUT + 12'(4 * p), rdata, err);
      check_value($sformatf("reset entry %0d", p), 32'd0, rdata);
      check_value("reset entry pslverr", 32'd0, 32'(err));
    end

    for (int i = 0; i < N_CASES; i++) begin
      run_case(cases[i]);
    end

    // protocol errors
    write_reg(12'h0f0, 32'h0, err);
    check_value("unmapped write pslverr", 32'd1, 32'(err));
    read_reg(12'h400, rdata, err);
    check_value("unmapped read pslverr", 32'd1, 32'(err));
    write_reg(`CONV_ADDR_CTRL, 32'h3, err);
    check_value("ctrl both bits pslverr", 32'd1, 32'(err));
    read_reg(`CONV_ADDR_STATUS, rdata, err);
    check_value("no run after bad ctrl", 32'd0, rdata);
    read_reg(`CONV_BASE_OUT, rdata, err);
    check_value("entry kept after bad ctrl", model[0], rdata);
    read_reg(`CONV_BASE_IMG0 + 12'd8, rdata, err);
    check_value("image read data", 32'd0, rdata);
    check_value("image read pslverr", 32'd0, 32'(err));

    end_run();
  end

endmodule
